/* spi_pkg.sv */
package spi_pkg;

   // ##################################################
   // Widths
   // ##################################################

   localparam int aw       = 32;             // Architecture address width
   localparam int pw       = 2 * aw + 40;    // Emesh packet width, 104
   localparam int sw       = 8;              // Serial word width
   localparam int pw_bytes = pw / sw;        // Bytes in a full packet, 13

   typedef logic [3:0]    size_t;            // Serializer byte count, holds pw_bytes
   typedef logic [sw-1:0] byte_t;            // One FIFO entry

   // ##################################################
   // Emesh packet
   // ##################################################

   // First member sits at the top of the vector
   typedef struct packed {
      logic [aw-1:0] srcaddr;                // Source / return address
      logic [aw-1:0] data;                   // Write data
      logic [aw-1:0] dstaddr;                // Destination address
      logic [4:0]    ctrlmode;               // Not used by the transmit path
      logic [1:0]    datamode;               // Transfer size code
      logic          write;                  // Write flag, bit 0
   } emesh_packet_t;

   // ##################################################
   // Register map and datamode codes
   // ##################################################

   // Index into dstaddr[7:2]
   localparam logic [5:0] spi_tx_addr = 6'h08;

   localparam logic [1:0] dm_byte   = 2'd0;  // 1 byte
   localparam logic [1:0] dm_half   = 2'd1;  // 2 bytes
   localparam logic [1:0] dm_word   = 2'd2;  // 4 bytes
   localparam logic [1:0] dm_double = 2'd3;  // 8 bytes

endpackage

/* par2ser.sv */
module par2ser (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   load,        // Capture din and datasize
   input  logic [spi_pkg::pw-1:0] din,
   input  spi_pkg::size_t         datasize,    // Bytes to emit
   input  logic                   wait_in,     // Back-pressure from the FIFO
   output spi_pkg::byte_t         dout,
   output logic                   access_out,  // Byte strobe
   output logic                   wait_out     // Busy while draining a packet
);

   logic [spi_pkg::pw-1:0] shreg;              // Word being drained
   spi_pkg::size_t         remain;             // Bytes still to emit
   logic                   busy;
   logic                   step;               // One byte leaves this cycle

   assign busy = (remain != '0);
   assign step = busy & ~wait_in;              // Hold while FIFO is nearly full

   // ##################################################
   // Byte counter
   // ##################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         remain <= '0;
      end else if (load) begin
         remain <= datasize;                   // New packet
      end else if (step) begin
         remain <= remain - spi_pkg::size_t'(1);
      end
   end

   // Lowest byte of the shift register leaves first
   always_ff @(posedge clk) begin
      if (load) begin
         shreg <= din;
      end else if (step) begin
         shreg <= shreg >> spi_pkg::sw;        // Next byte into the bottom
      end
   end

   assign dout       = shreg[spi_pkg::sw-1:0];
   assign access_out = step;
   assign wait_out   = busy;                   // High for the whole drain

   // ##################################################
   // Checks
   // ##################################################

   // The decoder must gate its load with our wait
   a_no_load_when_busy : assert property (
      @(posedge clk) disable iff (!arst_n)
      load |-> !wait_out
   ) else $error("par2ser loaded while still draining a packet");

endmodule

/* fifo_sync.sv */
module fifo_sync #(
   parameter int depth = 16                    // Entries
) (
   input  logic           clk,
   input  logic           arst_n,
   input  spi_pkg::byte_t din,
   input  logic           wr_en,
   input  logic           rd_en,               // Pop the head entry
   output spi_pkg::byte_t dout,                // Head entry, valid while !empty
   output logic           empty,
   output logic           full,
   output logic           almost_full          // Count at least depth-2
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   spi_pkg::byte_t   mem [depth];              // Storage, no reset
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;                    // Occupancy
   logic             do_wr;
   logic             do_rd;

   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   // ##################################################
   // Pointers and occupancy
   // ##################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // Both or neither
         endcase
      end
   end

   assign dout        = mem[rd_ptr];           // Fall-through head
   assign empty       = (count == '0);
   assign full        = (count == cnt_w'(depth));
   assign almost_full = (count >= cnt_w'(depth - 2));

   // Producer and consumer must respect the flags
   a_no_write_full : assert property (
      @(posedge clk) disable iff (!arst_n)
      full |-> !wr_en
   ) else $error("fifo_sync written while full");

   a_no_read_empty : assert property (
      @(posedge clk) disable iff (!arst_n)
      empty |-> !rd_en
   ) else $error("fifo_sync read while empty");

endmodule

/* spi_master_fifo.sv */
module spi_master_fifo #(
   parameter int depth = 16                    // FIFO entries
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   emode,       // Send the whole packet
   input  logic                   access_in,   // Core strobe
   input  logic [spi_pkg::pw-1:0] packet_in,
   output logic                   wait_out,    // Core must hold its strobe
   input  logic                   fifo_read,   // Pop from the shift engine
   output logic                   fifo_empty,
   output spi_pkg::byte_t         fifo_dout
);

   spi_pkg::emesh_packet_t pkt;                // Field view of packet_in
   logic                   tx_write;
   logic                   load;
   spi_pkg::size_t         datasize;
   logic [spi_pkg::pw-1:0] tx_data;
   spi_pkg::byte_t         fifo_din;
   logic                   fifo_wr;
   logic                   fifo_afull;

   // ##################################################
   // Decode
   // ##################################################

   assign pkt      = packet_in;
   assign tx_write = access_in & pkt.write
                   & (pkt.dstaddr[7:2] == spi_pkg::spi_tx_addr);  // TX register only
   assign load     = tx_write & ~wait_out;     // Drop strobes while draining

   always_comb begin
      if (emode) begin
         datasize = spi_pkg::size_t'(spi_pkg::pw_bytes);  // Every byte
      end else begin
         case (pkt.datamode)
            spi_pkg::dm_byte:   datasize = 4'd1;
            spi_pkg::dm_half:   datasize = 4'd2;
            spi_pkg::dm_word:   datasize = 4'd4;
            spi_pkg::dm_double: datasize = 4'd8;
            default:            datasize = 4'd1;
         endcase
      end
   end

   // Normal mode: data low, then srcaddr, zeros on top
   assign tx_data = emode ? packet_in
                  : {{(spi_pkg::pw - 2 * spi_pkg::aw){1'b0}}, pkt.srcaddr, pkt.data};

   // ##################################################
   // Serializer and byte queue
   // ##################################################

   par2ser i_par2ser (
      .clk        (clk),
      .arst_n     (arst_n),
      .load       (load),
      .din        (tx_data),
      .datasize   (datasize),
      .wait_in    (fifo_afull),
      .dout       (fifo_din),
      .access_out (fifo_wr),
      .wait_out   (wait_out)
   );

   fifo_sync #(
      .depth (depth)
   ) i_fifo_sync (
      .clk         (clk),
      .arst_n      (arst_n),
      .din         (fifo_din),
      .wr_en       (fifo_wr),
      .rd_en       (fifo_read),
      .dout        (fifo_dout),
      .empty       (fifo_empty),
      .full        (),                         // almost_full stalls first
      .almost_full (fifo_afull)
   );

endmodule

/* spi_master_io.sv */
module spi_master_io #(
   parameter int clkdiv = 2                    // sclk half period in clk cycles
) (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           fifo_empty,
   input  spi_pkg::byte_t fifo_dout,           // Head byte
   output logic           fifo_read,           // One-cycle pop
   output logic           sclk,
   output logic           mosi,
   output logic           ss_n
);

   localparam int div_w = (clkdiv > 1) ? $clog2(clkdiv) : 1;

   typedef enum logic [1:0] {
      st_idle,                                 // ss_n high while waiting for data
      st_shift,                                // Bits going out
      st_finish                                // Last half period before ss_n rises
   } state_t;

   state_t           state;
   logic [div_w-1:0] div_cnt;                  // Half-period divider
   logic [2:0]       bit_cnt;                  // Bit within the byte
   spi_pkg::byte_t   shreg;                    // MSB drives mosi
   logic             tick;                     // Half period elapsed
   logic             last_edge;                // Falling edge ending bit 7
   logic             pop;

   assign tick      = (div_cnt == div_w'(clkdiv - 1));
   assign last_edge = (state == st_shift) & tick & sclk & (bit_cnt == 3'd7);
   assign pop       = ~fifo_empty & ((state == st_idle) | last_edge);
   assign fifo_read = pop;
   assign mosi      = shreg[7];

   // ##################################################
   // Shift FSM
   // ##################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= st_idle;
         div_cnt <= '0;
         bit_cnt <= '0;
         sclk    <= 1'b0;                      // Mode 0 idle level
         ss_n    <= 1'b1;
         shreg   <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (pop) begin
                  shreg   <= fifo_dout;        // First bit on mosi before first rise
                  ss_n    <= 1'b0;
                  div_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= st_shift;
               end
            end
            st_shift: begin
               if (tick) begin
                  div_cnt <= '0;
                  sclk    <= ~sclk;
                  if (sclk) begin              // Falling edge ends the bit
                     if (bit_cnt == 3'd7) begin
                        if (pop) begin
                           shreg   <= fifo_dout;  // Next byte follows without a gap
                           bit_cnt <= '0;
                        end else begin
                           state <= st_finish;
                        end
                     end else begin
                        bit_cnt <= bit_cnt + 3'd1;
                        shreg   <= {shreg[6:0], 1'b0};  // mosi moves on the fall
                     end
                  end
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            st_finish: begin
               if (tick) begin
                  div_cnt <= '0;
                  ss_n    <= 1'b1;             // Burst over
                  state   <= st_idle;
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Select only rises after all eight bits of the last byte
   a_ss_after_byte : assert property (
      @(posedge clk) disable iff (!arst_n)
      $rose(ss_n) |-> ($past(bit_cnt) == 3'd7) && !$past(sclk)
   ) else $error("ss_n released in the middle of a byte");

endmodule

/* spi_master.sv */
module spi_master #(
   parameter int depth  = 16,                  // FIFO entries
   parameter int clkdiv = 2                    // sclk half period
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   emode,       // Whole-packet transfers
   input  logic                   access_in,
   input  logic [spi_pkg::pw-1:0] packet_in,
   output logic                   wait_out,
   output logic                   sclk,
   output logic                   mosi,
   output logic                   ss_n
);

   logic           fifo_read;                  // Engine pops a byte
   logic           fifo_empty;
   spi_pkg::byte_t fifo_dout;

   // ##################################################
   // Packet to byte queue
   // ##################################################

   spi_master_fifo #(
      .depth (depth)
   ) i_spi_master_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .emode      (emode),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .fifo_read  (fifo_read),
      .fifo_empty (fifo_empty),
      .fifo_dout  (fifo_dout)
   );

   // Pins
   spi_master_io #(
      .clkdiv (clkdiv)
   ) i_spi_master_io (
      .clk        (clk),
      .arst_n     (arst_n),
      .fifo_empty (fifo_empty),
      .fifo_dout  (fifo_dout),
      .fifo_read  (fifo_read),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss_n       (ss_n)
   );

endmodule

/* tb_spi_master.sv */
module tb_spi_master;

   localparam int depth       = 16;
   localparam int clkdiv      = 2;
   localparam int max_cases   = 32;
   localparam int quiet_cyc   = 8 + 4 * clkdiv;   // Stray byte would pull ss_n low by then

   logic                   clk;
   logic                   arst_n;
   logic                   emode;
   logic                   access_in;
   logic [spi_pkg::pw-1:0] packet_in;
   logic                   wait_out;
   logic                   sclk;
   logic                   mosi;
   logic                   ss_n;

   // Case table from the cases file
   string                  c_name  [max_cases];
   logic                   c_emode [max_cases];
   logic [spi_pkg::pw-1:0] c_pkt   [max_cases];
   int                     c_reps  [max_cases];
   int                     n_cases;
   bit                     loaded;                  // Watchdog starts once set

   spi_pkg::byte_t exp_q [$];                       // Bytes due on mosi
   spi_pkg::byte_t rx_q  [$];                       // Bytes seen on mosi
   spi_pkg::byte_t rx_shift;
   int             rx_bits;
   int             ss_falls;                        // Bursts started this case
   logic           sclk_d;
   logic           ss_d;
   int             errors;
   int             case_err;
   int             passed;
   int             failed;

   spi_master #(
      .depth  (depth),
      .clkdiv (clkdiv)
   ) i_spi_master (
      .clk       (clk),
      .arst_n    (arst_n),
      .emode     (emode),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .sclk      (sclk),
      .mosi      (mosi),
      .ss_n      (ss_n)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ##################################################
   // mosi monitor, mode 0 so bits are taken at the sclk rise
   // ##################################################

   always @(negedge clk) begin
      if (ss_n === 1'b0 && ss_d === 1'b1) begin
         ss_falls = ss_falls + 1;
      end
      if (ss_n !== 1'b0) begin
         rx_bits = 0;                               // Partial byte dropped between bursts
      end else if (sclk === 1'b1 && sclk_d === 1'b0) begin
         rx_shift = {rx_shift[6:0], mosi};          // MSB first
         if (rx_bits == 7) begin
            rx_q.push_back(rx_shift);
            rx_bits = 0;
         end else begin
            rx_bits = rx_bits + 1;
         end
      end
      sclk_d = sclk;
      ss_d   = ss_n;
   end

   // ##################################################
   // Expected values
   // ##################################################

   // Bytes one packet should put on mosi, zero if it is not a TX write
   function automatic int tx_bytes(input logic [spi_pkg::pw-1:0] pkt, input logic em);
      spi_pkg::emesh_packet_t p;
      p = pkt;
      if (!(p.write && p.dstaddr[7:2] == spi_pkg::spi_tx_addr)) begin
         return 0;
      end
      return em ? spi_pkg::pw_bytes : (1 << p.datamode);
   endfunction

   task automatic add_expected(input logic [spi_pkg::pw-1:0] pkt, input logic em,
                               input int reps);
      spi_pkg::emesh_packet_t p;
      logic [spi_pkg::pw-1:0] word;
      int                     n;
      p    = pkt;
      n    = tx_bytes(pkt, em);
      word = em ? pkt : {{(spi_pkg::pw - 64){1'b0}}, p.srcaddr, p.data};  // Data low
      for (int r = 0; r < reps; r++) begin
         for (int i = 0; i < n; i++) begin
            exp_q.push_back(word[8*i +: 8]);        // Lowest byte first
         end
      end
   endtask

   task automatic check_byte(input string name, input int idx,
                             input spi_pkg::byte_t exp, input spi_pkg::byte_t act);
      if (act !== exp) begin
         $display("[ERROR] %s byte %0d expected %02h actual %02h", name, idx, exp, act);
         case_err = case_err + 1;
      end
   endtask

   task automatic check_count(input string name, input string what, input int exp,
                              input int act);
      if (act != exp) begin
         $display("[ERROR] %s %s expected %0d actual %0d", name, what, exp, act);
         case_err = case_err + 1;
      end
   endtask

   task automatic check_pin(input string name, input string pin, input logic exp,
                            input logic act);
      if (act !== exp) begin
         $display("[ERROR] %s %s expected %b actual %b", name, pin, exp, act);
         case_err = case_err + 1;
      end
   endtask

   // ##################################################
   // Stimulus
   // ##################################################

   task automatic load_cases();
      int          fd;
      int          n;
      int          em;
      int          wr;
      int          dm;
      int          reps;
      string       line;
      string       name;
      logic [31:0] dst;
      logic [31:0] src;
      logic [31:0] dat;
      spi_pkg::emesh_packet_t p;
      n_cases = 0;
      fd = $fopen("spi_master_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open spi_master_cases.txt");
         errors = errors + 1;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() > 0 && line[0] != "#" && n_cases < max_cases) begin
            n = $sscanf(line, "%s %d %d %d %h %h %h %d", name, em, wr, dm, dst, src, dat,
                        reps);
            if (n == 8) begin                       // Blank and short lines skipped
               p          = '0;
               p.write    = wr[0];
               p.datamode = dm[1:0];
               p.dstaddr  = dst;
               p.srcaddr  = src;
               p.data     = dat;
               c_name[n_cases]  = name;
               c_emode[n_cases] = em[0];
               c_pkt[n_cases]   = p;
               c_reps[n_cases]  = reps;
               n_cases = n_cases + 1;
            end
         end
      end
      $fclose(fd);
      if (n_cases == 0) begin
         $display("No cases found in spi_master_cases.txt");
         errors = errors + 1;
      end
   endtask

   // Holds off while the serializer is busy, then one strobe cycle
   task automatic send_packet(input logic [spi_pkg::pw-1:0] pkt, input logic em);
      @(negedge clk);
      while (wait_out !== 1'b0) begin
         @(negedge clk);
      end
      access_in = 1'b1;
      packet_in = pkt;
      emode     = em;
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic run_case(input int k);
      int nexp;
      exp_q.delete();
      rx_q.delete();
      ss_falls = 0;
      case_err = 0;
      add_expected(c_pkt[k], c_emode[k], c_reps[k]);
      nexp = exp_q.size();
      for (int r = 0; r < c_reps[k]; r++) begin
         send_packet(c_pkt[k], c_emode[k]);
      end
      if (nexp == 0) begin
         repeat (quiet_cyc) @(negedge clk);
         check_count(c_name[k], "ss_n bursts", 0, ss_falls);
      end else begin
         while (rx_q.size() < nexp || ss_n !== 1'b1) begin
            @(negedge clk);                         // Burst ends with ss_n high
         end
      end
      check_count(c_name[k], "byte count", nexp, rx_q.size());
      for (int i = 0; i < nexp && i < rx_q.size(); i++) begin
         check_byte(c_name[k], i, exp_q[i], rx_q[i]);
      end
      $display("%-16s %s  %0d of %0d bytes", c_name[k], (case_err == 0) ? "ok" : "FAIL",
               rx_q.size(), nexp);
   endtask

   // ##################################################
   // Main sequence and watchdog
   // ##################################################

   initial begin
      arst_n    = 1'b0;
      emode     = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      errors    = 0;
      passed    = 0;
      failed    = 0;
      loaded    = 1'b0;
      sclk_d    = 1'b0;
      ss_d      = 1'b1;
      rx_shift  = '0;
      rx_bits   = 0;
      ss_falls  = 0;
      load_cases();
      loaded = 1'b1;
      repeat (8) @(negedge clk);
      arst_n = 1'b1;

      // Idle pins with no traffic
      case_err = 0;
      repeat (4) @(negedge clk);
      check_pin("reset_idle", "ss_n", 1'b1, ss_n);
      check_pin("reset_idle", "sclk", 1'b0, sclk);
      check_pin("reset_idle", "wait_out", 1'b0, wait_out);
      $display("%-16s %s", "reset_idle", (case_err == 0) ? "ok" : "FAIL");
      errors = errors + case_err;
      if (case_err == 0) passed = passed + 1;
      else failed = failed + 1;

      for (int k = 0; k < n_cases; k++) begin
         run_case(k);
         errors = errors + case_err;
         if (case_err == 0) passed = passed + 1;
         else failed = failed + 1;
      end

      $display("Cases passed %0d, failed %0d, errors %0d", passed, failed, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin
      int limit;
      wait (loaded);
      limit = 300;                                  // Reset and idle checks
      for (int k = 0; k < n_cases; k++) begin
         limit = limit + c_reps[k] * (tx_bytes(c_pkt[k], c_emode[k]) * 16 * clkdiv + 40)
               + quiet_cyc + 60;
      end
      repeat (limit) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the cases did not finish", limit);
      $display("Testbench failed");
      $finish;
   end

endmodule

/* spi_master_cases.txt */
# name emode write datamode dstaddr srcaddr data repeat
# addresses and data in hex, the rest decimal, dstaddr[7:2] of 8 selects the TX register
byte_dm0        0 1 0 00000020 a5a5a5a5 000000c3 1
half_dm1        0 1 1 00000020 11223344 0000b00f 1
word_dm2        0 1 2 00000020 55667788 deadbeef 1
double_dm3      0 1 3 00000020 8badf00d 01234567 1
no_write        0 0 3 00000020 ffffffff ffffffff 1
after_no_write  0 1 1 00000020 00000000 00005a3c 1
other_reg       0 1 2 00000024 cafef00d 12345678 1
after_other     0 1 0 00000020 00000000 00000091 1
index_low_bits  0 1 2 00000023 0badc0de 87654321 1
upper_addr_bits 0 1 3 80001020 13579bdf 2468ace0 1
emode_dm0       1 1 0 00000020 fedcba98 76543210 1
emode_dm2       1 1 2 00000021 a1b2c3d4 e5f60718 1
emode_no_write  1 0 0 00000020 11111111 22222222 1
emode_other_reg 1 1 1 00000040 33333333 44444444 1
emode_burst     1 1 3 00000020 c0ffee00 5eed1234 3
normal_burst    0 1 3 00000020 0f1e2d3c 4b5a6978 4
tail_byte       0 1 0 00000020 00000000 0000007e 1

/* spi_master.f */
spi_pkg.sv
par2ser.sv
fifo_sync.sv
spi_master_fifo.sv
spi_master_io.sv
spi_master.sv
tb_spi_master.sv

/* Bender.yml */
package:
  name: spi_master

sources:
  - spi_pkg.sv
  - par2ser.sv
  - fifo_sync.sv
  - spi_master_fifo.sv
  - spi_master_io.sv
  - spi_master.sv
  - target: test
    files:
      - tb_spi_master.sv
